// ==== flist.f ====
hw/soc_pkg.sv
hw/cpu_decode.sv
hw/cpu_execute.sv
hw/bus_split.sv
hw/int_mem.sv
hw/uart_tx.sv
hw/system.sv
+incdir+verif
verif/tb_system.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_system \
   -f flist.f -o tb_system_sim
./obj_dir/tb_system_sim 2>&1 | tee sim.log
if grep -q "Test completed successfully" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

// ==== verif/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

//////////////////////////////////////////////////
// reference model of the instruction set
//////////////////////////////////////////////////

logic [7:0] model_regs [4];
logic [7:0] model_dmem [DMEM_DEPTH];
// alu or round trip test that each register value feeds
int         model_src [4];
logic [7:0] exp_bytes [$];
int         exp_tests [$];

task automatic model_step(input logic [15:0] instr, input bit burst);
   logic [3:0] op;
   logic [1:0] rd;
   logic [1:0] rs;
   logic [7:0] imm;
   op  = instr[15:12];
   rd  = instr[11:10];
   rs  = instr[9:8];
   imm = instr[7:0];
   case (op)
      LDI: begin
         model_regs[rd] = imm;
         model_src[rd]  = T_ALU;
      end
      ADD, XOR: begin
         if (op == ADD) begin
            model_regs[rd] = model_regs[rd] + model_regs[rs];
         end else begin
            model_regs[rd] = model_regs[rd] ^ model_regs[rs];
         end
         if (model_src[rs] == T_ROUND) begin
            model_src[rd] = T_ROUND;
         end
      end
      LD: begin
         model_regs[rd] = model_dmem[imm[6:0]];
         model_src[rd]  = T_ROUND;
      end
      ST: begin
         if (imm[PERIPH_BIT]) begin
            exp_bytes.push_back(model_regs[rs]);
            exp_tests.push_back(burst ? T_BURST : model_src[rs]);
         end else begin
            model_dmem[imm[6:0]] = model_regs[rs];
         end
      end
      default: ;
   endcase
endtask

// 8N1 decoder sampling half a clock into each bit
task automatic receive_frame(output logic [7:0] data, output bit stop_ok);
   do begin
      @(negedge clk);
   end while (txd !== 1'b0);
   for (int b = 0; b < 8; b++) begin
      repeat (BAUD_DIV) @(negedge clk);
      data[b] = txd;
   end
   repeat (BAUD_DIV) @(negedge clk);
   stop_ok = (txd === 1'b1);
endtask

`endif

// ==== verif/tb_system.sv ====
`timescale 1ns/1ps

module tb_system
   import soc_pkg::*;
();

   localparam int BAUD_DIV        = 4;
   localparam int PROG_CREDITS    = 2;
   localparam int RAND_LEN        = 34;
   localparam int PROG_LEN        = RAND_LEN + 7;
   localparam int FRAME_CYCLES    = 10 * BAUD_DIV;
   localparam int WATCHDOG_CYCLES = PROG_LEN * (FRAME_CYCLES + 10) + 20 * BAUD_DIV + 100;
   localparam int LOAD_LIMIT      = 4 * PROG_LEN + 20;
   localparam int NUM_TESTS       = 6;
   localparam int T_RESET         = 0;
   localparam int T_CREDIT        = 1;
   localparam int T_ALU           = 2;
   localparam int T_ROUND         = 3;
   localparam int T_BURST         = 4;
   localparam int T_HALT          = 5;

   logic        clk = 1'b0;
   logic        rst_n;
   logic        prog_valid;
   logic [15:0] prog_data;
   logic        prog_last;
   logic        prog_credit;
   logic        trap;
   logic        txd;

   int          errors [NUM_TESTS];
   int          checks [NUM_TESTS];
   string       test_names [NUM_TESTS] = '{"reset_state", "credit_flow", "alu_results",
                                           "mem_round_trip", "back_pressure", "halt"};
   int unsigned lcg_state = 60;
   logic [15:0] prog [$];
   int          rx_count;
   int          n_expected;

   `include "tb_model.svh"

   system #(
      .BAUD_DIV     (BAUD_DIV),
      .PROG_CREDITS (PROG_CREDITS)
   ) i_system (
      .clk         (clk),
      .rst_n       (rst_n),
      .trap        (trap),
      .prog_valid  (prog_valid),
      .prog_data   (prog_data),
      .prog_last   (prog_last),
      .prog_credit (prog_credit),
      .txd         (txd)
   );

   always #5 clk = ~clk;

   function automatic int unsigned lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic check_value(input int t, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks[t]++;
      assert (actual === expected) else begin
         $display("CHECK FAILED %s: expected %0h, actual %0h", test_names[t], expected, actual);
         errors[t]++;
      end
   endtask

   task automatic check_true(input int t, input bit cond, input string msg);
      checks[t]++;
      assert (cond) else begin
         $display("ERROR %s: %s", test_names[t], msg);
         errors[t]++;
      end
   endtask

   task automatic report_test(input int t);
      $display("test %s: %s (%0d checks, %0d errors)", test_names[t],
               (errors[t] == 0) ? "PASS" : "FAIL", checks[t], errors[t]);
   endtask

   task automatic emit(input logic [15:0] instr, input bit burst);
      prog.push_back(instr);
      model_step(instr, burst);
   endtask

   //////////////////////////////////////////////////
   // random straight-line program
   //////////////////////////////////////////////////

   task automatic gen_program();
      int unsigned r;
      int          sel;
      logic [3:0]  op;
      logic [7:0]  addr;
      logic [7:0]  stored [$];
      for (int i = 0; i < 4; i++) begin
         model_regs[i] = '0;
         model_src[i]  = T_ALU;
      end
      for (int i = 0; i < RAND_LEN; i++) begin
         r    = lcg_next();
         sel  = int'(r[31:24] % 5);
         addr = r[23:16];
         case (sel)
            0: op = LDI;
            1: op = ADD;
            2: op = XOR;
            3: op = LD;
            default: op = ST;
         endcase
         // loads only read bytes stored earlier in the program
         if (op == ST && r[11]) begin
            addr[PERIPH_BIT] = 1'b1;
         end else if (op == ST) begin
            addr = {5'd0, addr[2:0]};
            stored.push_back(addr);
         end else if (op == LD && stored.size() == 0) begin
            op = LDI;
         end else if (op == LD) begin
            addr = stored[r[7:4] % stored.size()];
         end
         emit({op, r[15:14], r[13:12], addr}, 1'b0);
      end
      // fixed tail with one round trip and then stores straight into a busy transmitter
      emit({ST, 2'd0, 2'd1, 8'h10}, 1'b0);
      emit({LD, 2'd3, 2'd0, 8'h10}, 1'b0);
      emit({ST, 2'd0, 2'd3, 8'h80}, 1'b0);
      emit({ST, 2'd0, 2'd0, 8'h81}, 1'b1);
      emit({ST, 2'd0, 2'd1, 8'h82}, 1'b1);
      emit({ST, 2'd0, 2'd2, 8'h83}, 1'b1);
      emit({HALT, 12'd0}, 1'b0);
   endtask

   task automatic check_reset_outputs();
      check_value(T_RESET, 32'd0, {31'd0, trap});
      check_value(T_RESET, 32'd0, {31'd0, prog_credit});
      check_value(T_RESET, 32'd1, {31'd0, txd});
   endtask

   // loader side of the credit port
   task automatic load_program();
      int credits;
      int sent;
      int pulses;
      int cycles;
      credits = PROG_CREDITS;
      sent    = 0;
      pulses  = 0;
      cycles  = 0;
      while ((sent < prog.size() || credits < PROG_CREDITS) && cycles < LOAD_LIMIT) begin
         @(posedge clk);
         #1;
         if (prog_credit) begin
            pulses++;
            credits++;
         end
         check_true(T_CREDIT, credits <= PROG_CREDITS, "credit returned for no word");
         if (sent < prog.size()) begin
            check_value(T_RESET, 32'd0, {31'd0, trap});
            check_value(T_RESET, 32'd1, {31'd0, txd});
         end
         if (sent < prog.size() && credits > 0) begin
            prog_valid = 1'b1;
            prog_data  = prog[sent];
            prog_last  = (sent == prog.size() - 1);
            credits--;
            sent++;
         end else begin
            prog_valid = 1'b0;
            prog_last  = 1'b0;
         end
         cycles++;
      end
      prog_valid = 1'b0;
      prog_last  = 1'b0;
      check_true(T_CREDIT, sent == prog.size(),
                 $sformatf("load stalled after %0d of %0d words", sent, prog.size()));
      check_value(T_CREDIT, sent, pulses);
      check_value(T_CREDIT, PROG_CREDITS, credits);
   endtask

   //////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////

   initial begin : main_seq
      int cycles;
      int n_fail;
      int rx_at_halt;
      rst_n      = 1'b0;
      prog_valid = 1'b0;
      prog_data  = '0;
      prog_last  = 1'b0;
      gen_program();
      n_expected = exp_bytes.size();
      // registers are defined from the first edge on
      @(posedge clk);
      repeat (2) begin
         @(negedge clk);
         check_reset_outputs();
         @(posedge clk);
      end
      #1;
      rst_n = 1'b1;
      load_program();
      report_test(T_RESET);
      report_test(T_CREDIT);

      cycles = 0;
      while (trap !== 1'b1 && cycles < WATCHDOG_CYCLES) begin
         @(negedge clk);
         cycles++;
      end
      check_true(T_HALT, trap === 1'b1, "trap never rose");
      // at most the last frame is still on the line
      check_true(T_HALT, rx_count >= n_expected - 1,
                 $sformatf("trap rose with only %0d of %0d frames out", rx_count, n_expected));
      while (rx_count < n_expected && cycles < WATCHDOG_CYCLES) begin
         @(negedge clk);
         cycles++;
      end
      check_value(T_BURST, n_expected, rx_count);
      check_true(T_ALU, checks[T_ALU] > 0, "no alu bytes were transmitted");
      check_true(T_ROUND, checks[T_ROUND] > 0, "no round trip bytes were transmitted");
      report_test(T_ALU);
      report_test(T_ROUND);
      report_test(T_BURST);

      rx_at_halt = rx_count;
      repeat (20 * BAUD_DIV) begin
         @(negedge clk);
         check_value(T_HALT, 32'd1, {31'd0, trap});
         check_value(T_HALT, 32'd1, {31'd0, txd});
      end
      check_value(T_HALT, rx_at_halt, rx_count);
      report_test(T_HALT);

      n_fail = 0;
      for (int t = 0; t < NUM_TESTS; t++) begin
         if (errors[t] != 0) begin
            n_fail++;
         end
      end
      $display("summary: %0d tests passed, %0d tests failed", NUM_TESTS - n_fail, n_fail);
      if (n_fail == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // compares every frame on txd against the model in order
   initial begin : tx_monitor
      logic [7:0] got;
      bit         stop_ok;
      int         t;
      forever begin
         receive_frame(got, stop_ok);
         rx_count++;
         check_true(T_BURST, stop_ok, $sformatf("frame %0d has a bad stop bit", rx_count));
         if (exp_bytes.size() == 0) begin
            check_true(T_ALU, 1'b0, $sformatf("unexpected frame with value %02h", got));
         end else begin
            t = exp_tests.pop_front();
            check_value(t, exp_bytes.pop_front(), got);
         end
      end
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Test failed");
      $finish;
   end

endmodule

// ==== hw/system.sv ====
`timescale 1ns/1ps

module system
   import soc_pkg::*;
#(
   parameter int BAUD_DIV     = 4,
   parameter int PROG_CREDITS = 2
) (
   input  logic        clk,
   input  logic        rst_n,
   output logic        trap,
   input  logic        prog_valid,
   input  logic [15:0] prog_data,
   input  logic        prog_last,
   output logic        prog_credit,
   output logic        txd
);

   logic       cpu_rst_n;
   logic       boot;
   ibus_req_t  cpu_i_req;
   ibus_resp_t cpu_i_resp;
   decoded_t   dec;
   logic       dec_valid;
   logic       done;
   bus_req_t   cpu_d_req;
   bus_resp_t  cpu_d_resp;
   bus_req_t   mem_d_req;
   bus_resp_t  mem_d_resp;
   bus_req_t   uart_req;
   bus_resp_t  uart_resp;

   // processor stays in reset while the program is loaded
   assign cpu_rst_n = rst_n && !boot;

   //////////////////////////////////////////////////
   // processor
   //////////////////////////////////////////////////

   cpu_decode i_decode (
      .clk       (clk),
      .rst_n     (cpu_rst_n),
      .ibus_req  (cpu_i_req),
      .ibus_resp (cpu_i_resp),
      .dec       (dec),
      .dec_valid (dec_valid),
      .done      (done)
   );

   cpu_execute i_execute (
      .clk       (clk),
      .rst_n     (cpu_rst_n),
      .dec       (dec),
      .dec_valid (dec_valid),
      .done      (done),
      .dbus_req  (cpu_d_req),
      .dbus_resp (cpu_d_resp),
      .trap      (trap)
   );

   //////////////////////////////////////////////////
   // memory and transmitter
   //////////////////////////////////////////////////

   bus_split i_split (
      .m_req     (cpu_d_req),
      .m_resp    (cpu_d_resp),
      .mem_req   (mem_d_req),
      .uart_req  (uart_req),
      .mem_resp  (mem_d_resp),
      .uart_resp (uart_resp)
   );

   int_mem #(
      .PROG_CREDITS (PROG_CREDITS)
   ) i_mem (
      .clk         (clk),
      .rst_n       (rst_n),
      .prog_valid  (prog_valid),
      .prog_data   (prog_data),
      .prog_last   (prog_last),
      .prog_credit (prog_credit),
      .boot        (boot),
      .i_req       (cpu_i_req),
      .i_resp      (cpu_i_resp),
      .d_req       (mem_d_req),
      .d_resp      (mem_d_resp)
   );

   uart_tx #(
      .BAUD_DIV (BAUD_DIV)
   ) i_uart (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (uart_req),
      .resp  (uart_resp),
      .txd   (txd)
   );

endmodule

// ==== hw/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx
   import soc_pkg::*;
#(
   parameter int BAUD_DIV = 4
) (
   input  logic      clk,
   input  logic      rst_n,
   input  bus_req_t  req,
   output bus_resp_t resp,
   output logic      txd
);

   localparam int DIV_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;

   typedef enum logic {
      S_IDLE,
      S_SEND
   } state_e;

   state_e           state;
   logic [9:0]       frame;
   logic [3:0]       bit_cnt;
   logic [DIV_W-1:0] baud_cnt;
   logic             start;
   logic             bit_end;

   // busy for the whole frame and reads see zero
   assign resp.ready = (state == S_IDLE);
   assign resp.rdata = '0;
   assign start      = req.valid && req.we && (state == S_IDLE);
   assign bit_end    = (state == S_SEND) && (baud_cnt == DIV_W'(BAUD_DIV - 1));
   assign txd        = (state == S_SEND) ? frame[0] : 1'b1;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state    <= S_IDLE;
         bit_cnt  <= '0;
         baud_cnt <= '0;
      end else if (start) begin
         state    <= S_SEND;
         bit_cnt  <= '0;
         baud_cnt <= '0;
      end else if (bit_end) begin
         baud_cnt <= '0;
         // start bit, eight data bits and the stop bit
         if (bit_cnt == 4'd9) begin
            state <= S_IDLE;
         end else begin
            bit_cnt <= bit_cnt + 4'd1;
         end
      end else if (state == S_SEND) begin
         baud_cnt <= baud_cnt + 1'b1;
      end
   end

   // lsb first with the stop bit shifting in from the top
   always_ff @(posedge clk) begin
      if (start) begin
         frame <= {1'b1, req.wdata, 1'b0};
      end else if (bit_end) begin
         frame <= {1'b1, frame[9:1]};
      end
   end

endmodule

// ==== hw/int_mem.sv ====
`timescale 1ns/1ps

module int_mem
   import soc_pkg::*;
#(
   parameter int PROG_CREDITS = 2
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        prog_valid,
   input  logic [15:0] prog_data,
   input  logic        prog_last,
   output logic        prog_credit,
   output logic        boot,
   input  ibus_req_t   i_req,
   output ibus_resp_t  i_resp,
   input  bus_req_t    d_req,
   output bus_resp_t   d_resp
);

   localparam int IMEM_AW = $clog2(IMEM_DEPTH);
   localparam int DMEM_AW = $clog2(DMEM_DEPTH);
   localparam int CRED_W  = $clog2(PROG_CREDITS + 1);

   logic [15:0]        imem [IMEM_DEPTH];
   logic [7:0]         dmem [DMEM_DEPTH];
   logic [IMEM_AW-1:0] wr_ptr;
   logic               load;
   logic               i_ready;
   logic [15:0]        i_instr;
   logic               d_ready;
   logic [7:0]         d_rdata;
   logic [DMEM_AW-1:0] d_addr;
   logic [CRED_W-1:0]  sender_credits;

   assign load   = boot && prog_valid;
   assign d_addr = d_req.addr[DMEM_AW-1:0];
   assign i_resp = '{ready: i_ready, instr: i_instr};
   assign d_resp = '{ready: d_ready, rdata: d_rdata};

   //////////////////////////////////////////////////
   // boot loader
   //////////////////////////////////////////////////

   // each accepted word gives its credit back one cycle later
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         boot        <= 1'b1;
         wr_ptr      <= '0;
         prog_credit <= 1'b0;
      end else begin
         prog_credit <= load;
         if (load) begin
            wr_ptr <= wr_ptr + 1'b1;
            if (prog_last) begin
               boot <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         imem[wr_ptr] <= prog_data;
      end
   end

   //////////////////////////////////////////////////
   // fetch and data ports
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         i_ready <= 1'b0;
         d_ready <= 1'b0;
      end else begin
         i_ready <= i_req.valid;
         // one ready pulse per held request
         d_ready <= d_req.valid && !d_ready;
      end
   end

   always_ff @(posedge clk) begin
      i_instr <= imem[i_req.addr];
      if (d_req.valid && !d_ready) begin
         if (d_req.we) begin
            dmem[d_addr] <= d_req.wdata;
         end
         d_rdata <= dmem[d_addr];
      end
   end

   // mirror of the loader's credit count
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sender_credits <= CRED_W'(PROG_CREDITS);
      end else begin
         sender_credits <= sender_credits - CRED_W'(prog_valid) + CRED_W'(prog_credit);
      end
   end

   a_credit_avail: assert property (@(posedge clk) disable iff (!rst_n)
      prog_valid |-> sender_credits != '0);

endmodule

// ==== hw/bus_split.sv ====
`timescale 1ns/1ps

module bus_split
   import soc_pkg::*;
(
   input  bus_req_t  m_req,
   output bus_resp_t m_resp,
   output bus_req_t  mem_req,
   output bus_req_t  uart_req,
   input  bus_resp_t mem_resp,
   input  bus_resp_t uart_resp
);

   logic sel_uart;

   // upper half of the data space belongs to the transmitter
   assign sel_uart = m_req.addr[PERIPH_BIT];

   always_comb begin
      mem_req        = m_req;
      mem_req.valid  = m_req.valid && !sel_uart;
      uart_req       = m_req;
      uart_req.valid = m_req.valid && sel_uart;
      m_resp         = sel_uart ? uart_resp : mem_resp;
   end

endmodule

// ==== hw/cpu_execute.sv ====
`timescale 1ns/1ps

module cpu_execute
   import soc_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  decoded_t  dec,
   input  logic      dec_valid,
   output logic      done,
   output bus_req_t  dbus_req,
   input  bus_resp_t dbus_resp,
   output logic      trap
);

   typedef enum logic [1:0] {
      S_READY,
      S_ACCESS,
      S_HALT
   } state_e;

   state_e     state;
   logic [7:0] regs [4];
   logic [7:0] rd_val;
   logic [7:0] rs_val;
   logic       is_mem;
   logic       wr_en;
   logic [7:0] wr_data;

   assign rd_val = regs[dec.rd];
   assign rs_val = regs[dec.rs];
   assign is_mem = (dec.op == LD) || (dec.op == ST);
   assign trap   = (state == S_HALT);

   // alu ops finish in the issue cycle and memory ops on ready
   always_comb begin
      done = 1'b0;
      if (state == S_READY && dec_valid) begin
         done = !is_mem && (dec.op != HALT);
      end else if (state == S_ACCESS) begin
         done = dbus_resp.ready;
      end
   end

   //////////////////////////////////////////////////
   // write-back
   //////////////////////////////////////////////////

   always_comb begin
      wr_en   = 1'b0;
      wr_data = rd_val;
      if (state == S_READY && dec_valid) begin
         case (dec.op)
            LDI: begin
               wr_en   = 1'b1;
               wr_data = dec.imm;
            end
            ADD: begin
               wr_en   = 1'b1;
               wr_data = rd_val + rs_val;
            end
            XOR: begin
               wr_en   = 1'b1;
               wr_data = rd_val ^ rs_val;
            end
            default: wr_en = 1'b0;
         endcase
      end else if (state == S_ACCESS && dbus_resp.ready && !dbus_req.we) begin
         wr_en   = 1'b1;
         wr_data = dbus_resp.rdata;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < 4; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[dec.rd] <= wr_data;
      end
   end

   //////////////////////////////////////////////////
   // data bus access and halt
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state    <= S_READY;
         dbus_req <= '0;
      end else begin
         case (state)
            S_READY: begin
               if (dec_valid && is_mem) begin
                  dbus_req.valid <= 1'b1;
                  dbus_req.we    <= (dec.op == ST);
                  dbus_req.addr  <= dec.imm;
                  dbus_req.wdata <= rs_val;
                  state          <= S_ACCESS;
               end else if (dec_valid && dec.op == HALT) begin
                  state <= S_HALT;
               end
            end
            S_ACCESS: begin
               if (dbus_resp.ready) begin
                  dbus_req.valid <= 1'b0;
                  state          <= S_READY;
               end
            end
            // parked until the next reset
            S_HALT:  state <= S_HALT;
            default: state <= S_READY;
         endcase
      end
   end

   a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
      dbus_req.valid && !dbus_resp.ready |=> $stable(dbus_req));

endmodule

// ==== hw/cpu_decode.sv ====
`timescale 1ns/1ps

module cpu_decode
   import soc_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   output ibus_req_t  ibus_req,
   input  ibus_resp_t ibus_resp,
   output decoded_t   dec,
   output logic       dec_valid,
   input  logic       done
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_FETCH,
      S_WAIT,
      S_EXEC
   } state_e;

   state_e     state;
   logic [7:0] pc;

   // a single fetch in flight and the word held until execute is done
   assign ibus_req.valid = (state == S_FETCH);
   assign ibus_req.addr  = pc;
   assign dec_valid      = (state == S_EXEC);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= S_IDLE;
         pc    <= '0;
      end else begin
         case (state)
            S_IDLE:  state <= S_FETCH;
            S_FETCH: state <= S_WAIT;
            S_WAIT: begin
               if (ibus_resp.ready) begin
                  state <= S_EXEC;
               end
            end
            S_EXEC: begin
               if (done) begin
                  pc    <= pc + 8'd1;
                  state <= S_FETCH;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // slice the fetched word straight into the decoded fields
   always_ff @(posedge clk) begin
      if (state == S_WAIT && ibus_resp.ready) begin
         dec <= decoded_t'(ibus_resp.instr);
      end
   end

   // a pending word never sees the answer of a second fetch
   a_no_fetch_pending: assert property (@(posedge clk) disable iff (!rst_n)
      dec_valid |-> !ibus_resp.ready);

   // execute only finishes what decode handed over
   a_done_has_instr: assert property (@(posedge clk) disable iff (!rst_n)
      done |-> dec_valid);

endmodule

// ==== hw/soc_pkg.sv ====
package soc_pkg;

   //////////////////////////////////////////////////
   // instruction set
   //////////////////////////////////////////////////

   // unlisted codes run as no-operation
   typedef enum logic [3:0] {
      LDI  = 4'h1,
      ADD  = 4'h2,
      XOR  = 4'h3,
      LD   = 4'h4,
      ST   = 4'h5,
      HALT = 4'hf
   } opcode_e;

   // same layout as the instruction word with op in the top nibble
   typedef struct packed {
      opcode_e    op;
      logic [1:0] rd;
      logic [1:0] rs;
      logic [7:0] imm;
   } decoded_t;

   //////////////////////////////////////////////////
   // buses
   //////////////////////////////////////////////////

   typedef struct packed {
      logic       valid;
      logic       we;
      logic [7:0] addr;
      logic [7:0] wdata;
   } bus_req_t;

   typedef struct packed {
      logic       ready;
      logic [7:0] rdata;
   } bus_resp_t;

   typedef struct packed {
      logic       valid;
      logic [7:0] addr;
   } ibus_req_t;

   typedef struct packed {
      logic        ready;
      logic [15:0] instr;
   } ibus_resp_t;

   // address map
   localparam int PERIPH_BIT = 7;
   localparam int IMEM_DEPTH = 256;
   localparam int DMEM_DEPTH = 128;

endpackage
